/* sim.f */
tcdm_pkg.sv
tcdm_req_if.sv
tcdm_bank_if.sv
tcdm_bank_select.sv
tcdm_arbiter.sv
tcdm_bank.sv
tcdm_resp_route.sv
tcdm_top.sv
tb_tcdm.sv

/* tb_tcdm.sv */
// Testbench for tcdm_top with LFSR stimulus, memory and round-robin model, and checks.
`timescale 1ns/1ps

module tb_tcdm;

  localparam int NP = 4;

  logic                                clk;
  logic                                rst_n;
  logic [NP-1:0]                       req_i;
  logic [NP-1:0][tcdm_pkg::ADDR_W-1:0] add_i;
  logic [NP-1:0][tcdm_pkg::BE_W-1:0]   be_i;
  logic [NP-1:0][tcdm_pkg::DATA_W-1:0] wdata_i;
  logic [NP-1:0]                       opc_i;
  logic [NP-1:0][tcdm_pkg::SRC_W-1:0]  src_i;
  logic [NP-1:0]                       gnt_o;
  logic [NP-1:0]                       valid_o;
  logic [NP-1:0][tcdm_pkg::DATA_W-1:0] rdata_o;
  logic [NP-1:0][tcdm_pkg::SRC_W-1:0]  src_o;

  // Pending request per port, held until granted.
  logic [NP-1:0]                       pend;
  logic [NP-1:0][tcdm_pkg::ADDR_W-1:0] p_add;
  logic [NP-1:0][tcdm_pkg::BE_W-1:0]   p_be;
  logic [NP-1:0][tcdm_pkg::DATA_W-1:0] p_wdata;
  logic [NP-1:0]                       p_opc;
  logic [NP-1:0][tcdm_pkg::SRC_W-1:0]  p_src;

  // Reference model state.
  logic [31:0]                         mem_m [64];
  logic [1:0]                          ptr_m [4];
  logic [NP-1:0]                       exp_valid;
  logic [NP-1:0][tcdm_pkg::DATA_W-1:0] exp_data;
  logic [NP-1:0][tcdm_pkg::SRC_W-1:0]  exp_src;
  logic [NP-1:0]                       gnt_seen;
  logic [31:0]                         lfsr;
  int                                  errors;
  int                                  checks;

  tcdm_top #(
    .N_PORTS          (4),
    .N_BANKS          (4),
    .BANK_WORDS       (16),
    .WORD_INTERLEAVING(1)
  ) dut_i (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .add_i(add_i), .be_i(be_i),
    .wdata_i(wdata_i), .opc_i(opc_i), .src_i(src_i), .gnt_o(gnt_o),
    .valid_o(valid_o), .rdata_o(rdata_o), .src_o(src_o)
  );

  always #20 clk = ~clk;

  // Taps 32, 22, 2, 1; one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error @%0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic drive();
    req_i   = pend;
    add_i   = p_add;
    be_i    = p_be;
    wdata_i = p_wdata;
    opc_i   = p_opc;
    src_i   = p_src;
  endtask

  task automatic post(input int p, input logic opc, input logic [31:0] addr,
                      input logic [3:0] be, input logic [31:0] data);
    pend[p]    = 1'b1;
    p_opc[p]   = opc;
    p_add[p]   = addr[tcdm_pkg::ADDR_W-1:0];
    p_be[p]    = be;
    p_wdata[p] = data;
    p_src[p]   = 2'(rand_bits(2));
  endtask

  // One clock cycle; checks sit just before the rising edge.
  task automatic step();
    logic [NP-1:0] m_gnt;
    logic [5:0]    a;
    int            p;
    int            win;
    drive();
    @(negedge clk);
    #18;
    check(valid_o, exp_valid, "valid_o");
    check(src_o, exp_src, "src_o");
    for (int q = 0; q < NP; q++) begin
      if (exp_valid[q]) begin
        check(rdata_o[q], exp_data[q], $sformatf("rdata_o port %0d", q));
      end
    end
    m_gnt = '0;
    for (int b = 0; b < 4; b++) begin
      win = -1;
      for (int k = 0; k < NP; k++) begin
        p = (ptr_m[b] + k) % NP;
        if (win < 0 && pend[p] && p_add[p][1:0] == b) begin
          win = p;
        end
      end
      if (win >= 0) begin
        m_gnt[win] = 1'b1;
        ptr_m[b]   = 2'((win + 1) % NP);
      end
    end
    check(gnt_o, m_gnt, "gnt_o");
    gnt_seen  = gnt_o;
    exp_valid = '0;
    for (int q = 0; q < NP; q++) begin
      a = p_add[q][5:0];
      if (m_gnt[q] && p_opc[q] == tcdm_pkg::OPC_READ) begin
        exp_valid[q] = 1'b1;
        exp_data[q]  = mem_m[a];
      end else if (m_gnt[q]) begin
        for (int y = 0; y < 4; y++) begin
          if (p_be[q][y]) mem_m[a][y*8 +: 8] = p_wdata[q][y*8 +: 8];
        end
      end
    end
    exp_src = p_src;
    pend    = pend & ~m_gnt;
    @(posedge clk);
    #2;
  endtask

  task automatic drain();
    int guard;
    guard = 0;
    while (|pend && guard < 64) begin
      step();
      guard++;
    end
    if (|pend) begin
      errors++;
      $display("timeout: pending requests were never granted");
      pend = '0;
    end
  endtask

  initial begin
    logic [31:0] addr;
    clk       = 0;
    rst_n     = 0;
    lfsr      = 32'h6fcf;
    errors    = 0;
    checks    = 0;
    pend      = '0;
    p_add     = '0;
    p_be      = '0;
    p_wdata   = '0;
    p_opc     = '0;
    p_src     = '0;
    exp_valid = '0;
    exp_data  = '0;
    exp_src   = '0;
    gnt_seen  = '0;
    for (int i = 0; i < 64; i++) mem_m[i] = '0;
    for (int b = 0; b < 4; b++) ptr_m[b] = '0;
    drive();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1;
    // Idle cycles followed by a zero read sweep.
    repeat (4) step();
    for (int w = 0; w < 64; w++) begin
      post(0, tcdm_pkg::OPC_READ, w, 4'h0, 0);
      drain();
    end
    // Single port write and read back; full enables first, partial after.
    for (int i = 0; i < 40; i++) begin
      addr = rand_bits(6);
      post(i % NP, tcdm_pkg::OPC_WRITE, addr, (i < 20) ? 4'hf : 4'(rand_bits(4)),
           rand_bits(32));
      drain();
      post(i % NP, tcdm_pkg::OPC_READ, addr, 4'h0, 0);
      drain();
    end
    // All ports on one bank.
    for (int i = 0; i < 12; i++) begin
      addr = rand_bits(2);
      for (int p = 0; p < NP; p++) begin
        post(p, 1'(rand_bits(1)), {4'(rand_bits(4)), addr[1:0]}, 4'(rand_bits(4)),
             rand_bits(32));
      end
      drain();
    end
    // Distinct banks are all granted together.
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < NP; p++) begin
        post(p, 1'(rand_bits(1)), {4'(rand_bits(4)), 2'(p)}, 4'hf, rand_bits(32));
      end
      step();
      check(gnt_seen, 4'hf, "parallel grants");
    end
    // Long random mix; upper address bits exercise the wrap.
    for (int i = 0; i < 300; i++) begin
      for (int p = 0; p < NP; p++) begin
        if (!pend[p] && rand_bits(1)) begin
          post(p, 1'(rand_bits(1)), rand_bits(8), 4'(rand_bits(4)), rand_bits(32));
        end else if (!pend[p]) begin
          p_src[p] = 2'(rand_bits(2));
        end
      end
      step();
    end
    drain();
    for (int w = 0; w < 64; w++) begin
      post(w % NP, tcdm_pkg::OPC_READ, w, 4'h0, 0);
      drain();
    end
    step();
    $display("errors: %0d checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tcdm_arbiter.sv */
// Per-bank round-robin arbitration and bank access steering.
`timescale 1ns/1ps

module tcdm_arbiter #(
  parameter int N_PORTS    = 4,
  parameter int N_BANKS    = 4,
  parameter int BANK_WORDS = 16
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  tcdm_req_if.arb                                   req,
  input  logic [N_PORTS-1:0][$clog2(N_BANKS)-1:0]    bank_i,
  input  logic [N_PORTS-1:0][$clog2(BANK_WORDS)-1:0] row_i,
  tcdm_bank_if.ctrl                                 bank
);

  localparam int BANK_W = $clog2(N_BANKS);
  localparam int PORT_W = $clog2(N_PORTS);

  logic [N_BANKS-1:0][PORT_W-1:0] ptr_q;
  logic [N_BANKS-1:0][PORT_W-1:0] win_idx;
  logic [N_BANKS-1:0]             win_valid;
  logic [N_PORTS-1:0]             gnt_d;

  // Scan from each bank's pointer and take the first requester.
  always_comb begin
    int p;
    gnt_d     = '0;
    win_valid = '0;
    win_idx   = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      for (int k = 0; k < N_PORTS; k++) begin
        p = (int'(ptr_q[b]) + k) % N_PORTS;
        if (!win_valid[b] && req.req[p] && (bank_i[p] == BANK_W'(b))) begin
          win_valid[b] = 1'b1;
          win_idx[b]   = PORT_W'(p);
        end
      end
      if (win_valid[b]) begin
        gnt_d[win_idx[b]] = 1'b1;
      end
    end
  end

  assign req.gnt = gnt_d;

  // Pointer moves just past the winner; idle banks hold.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else begin
      for (int b = 0; b < N_BANKS; b++) begin
        if (win_valid[b]) begin
          if (win_idx[b] == PORT_W'(N_PORTS - 1)) begin
            ptr_q[b] <= '0;
          end else begin
            ptr_q[b] <= win_idx[b] + 1'b1;
          end
        end
      end
    end
  end

  // Bank access fields come from the winning port.
  always_comb begin
    for (int b = 0; b < N_BANKS; b++) begin
      bank.en[b]    = win_valid[b];
      bank.we[b]    = win_valid[b] && (req.opc[win_idx[b]] == tcdm_pkg::OPC_WRITE);
      bank.row[b]   = row_i[win_idx[b]];
      bank.wdata[b] = req.wdata[win_idx[b]];
      bank.be[b]    = req.be[win_idx[b]];
    end
  end

endmodule

/* tcdm_bank.sv */
// Single memory bank with byte-enabled writes and a registered read port.
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int BANK_WORDS = 16,
  parameter int BANK_IDX   = 0
) (
  input  logic      clk,
  input  logic      rst_n,
  tcdm_bank_if.mem  bank
);

  localparam int ROW_W  = $clog2(BANK_WORDS);
  localparam int BYTE_W = tcdm_pkg::DATA_W / tcdm_pkg::BE_W;

  logic [tcdm_pkg::DATA_W-1:0] mem_q [BANK_WORDS];
  logic [tcdm_pkg::DATA_W-1:0] rdata_q;
  logic [ROW_W-1:0]            row;

  assign row = bank.row[BANK_IDX];

  // Contents start at zero.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (bank.en[BANK_IDX] && bank.we[BANK_IDX]) begin
      for (int b = 0; b < tcdm_pkg::BE_W; b++) begin
        if (bank.be[BANK_IDX][b]) begin
          mem_q[row][b*BYTE_W +: BYTE_W] <= bank.wdata[BANK_IDX][b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // Read data appears the cycle after the access.
  always_ff @(posedge clk) begin
    if (bank.en[BANK_IDX] && !bank.we[BANK_IDX]) begin
      rdata_q <= mem_q[row];
    end
  end

  assign bank.rdata[BANK_IDX] = rdata_q;

endmodule

/* tcdm_bank_if.sv */
// Per-bank access and read-data bundle between arbiter, banks and response router.
`timescale 1ns/1ps

interface tcdm_bank_if #(
  parameter int N_BANKS    = 4,
  parameter int BANK_WORDS = 16
);

  localparam int ROW_W = $clog2(BANK_WORDS);

  logic [N_BANKS-1:0]                       en;
  logic [N_BANKS-1:0]                       we;
  logic [N_BANKS-1:0][ROW_W-1:0]            row;
  logic [N_BANKS-1:0][tcdm_pkg::DATA_W-1:0] wdata;
  logic [N_BANKS-1:0][tcdm_pkg::BE_W-1:0]   be;
  logic [N_BANKS-1:0][tcdm_pkg::DATA_W-1:0] rdata;

  // Access steering from the arbiter.
  modport ctrl (
    output en, we, row, wdata, be
  );

  // Storage side; each bank drives only its own rdata slot.
  modport mem (
    input  en, we, row, wdata, be,
    output rdata
  );

  // Read-data consumer.
  modport rd (
    input rdata
  );

endinterface

/* tcdm_bank_select.sv */
// Address split into bank index and row, word-interleaved or block mapped.
`timescale 1ns/1ps

module tcdm_bank_select #(
  parameter int N_PORTS           = 4,
  parameter int N_BANKS           = 4,
  parameter int BANK_WORDS        = 16,
  parameter int WORD_INTERLEAVING = 1
) (
  tcdm_req_if.mon                                  req,
  output logic [N_PORTS-1:0][$clog2(N_BANKS)-1:0]    bank_o,
  output logic [N_PORTS-1:0][$clog2(BANK_WORDS)-1:0] row_o
);

  localparam int BANK_W = $clog2(N_BANKS);
  localparam int ROW_W  = $clog2(BANK_WORDS);
  localparam int MEM_W  = BANK_W + ROW_W;

  // Bits above MEM_W are ignored, so addresses wrap at the memory size.
  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    if (WORD_INTERLEAVING == 1) begin : g_word
      // Consecutive words land in consecutive banks.
      assign bank_o[p] = req.add[p][BANK_W-1:0];
      assign row_o[p]  = req.add[p][MEM_W-1:BANK_W];
    end else begin : g_block
      // Each bank holds one contiguous block.
      assign bank_o[p] = req.add[p][MEM_W-1:ROW_W];
      assign row_o[p]  = req.add[p][ROW_W-1:0];
    end
  end

endmodule

/* tcdm_pkg.sv */
// Shared word, byte-enable, address and tag widths plus opcode encodings.
package tcdm_pkg;

  // Data word width in bits.
  localparam int DATA_W = 32;

  // One enable per byte of the data word.
  localparam int BE_W = 4;

  // Word address width as seen on each master port.
  localparam int ADDR_W = 30;

  // Source tag carried with each request.
  localparam int SRC_W = 2;

  // Opcode values on the opc lines.
  localparam logic OPC_READ  = 1'b0;
  localparam logic OPC_WRITE = 1'b1;

endpackage

/* tcdm_req_if.sv */
// Per-port request bundle with grants, shared by the top level and inner blocks.
`timescale 1ns/1ps

interface tcdm_req_if #(
  parameter int N_PORTS = 4
);

  logic [N_PORTS-1:0]                       req;
  logic [N_PORTS-1:0][tcdm_pkg::ADDR_W-1:0] add;
  logic [N_PORTS-1:0][tcdm_pkg::BE_W-1:0]   be;
  logic [N_PORTS-1:0][tcdm_pkg::DATA_W-1:0] wdata;
  logic [N_PORTS-1:0]                       opc;
  logic [N_PORTS-1:0][tcdm_pkg::SRC_W-1:0]  src;
  logic [N_PORTS-1:0]                       gnt;

  // Master side, drives the request fields.
  modport host (
    output req, add, be, wdata, opc, src,
    input  gnt
  );

  // Arbitration side, issues the grants.
  modport arb (
    input  req, be, wdata, opc,
    output gnt
  );

  // Observers of the request stream.
  modport mon (
    input add, src, opc, req, gnt
  );

endinterface

/* tcdm_resp_route.sv */
// Read response routing with valid pulse and one-cycle tag echo per port.
`timescale 1ns/1ps

module tcdm_resp_route #(
  parameter int N_PORTS = 4,
  parameter int N_BANKS = 4
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  tcdm_req_if.mon                                   req,
  input  logic [N_PORTS-1:0][$clog2(N_BANKS)-1:0]    bank_i,
  tcdm_bank_if.rd                                   bank,
  output logic [N_PORTS-1:0][tcdm_pkg::DATA_W-1:0]   rdata_o,
  output logic [N_PORTS-1:0]                        valid_o,
  output logic [N_PORTS-1:0][tcdm_pkg::SRC_W-1:0]    src_o
);

  localparam int BANK_W = $clog2(N_BANKS);

  logic [N_PORTS-1:0]              rd_d;
  logic [N_PORTS-1:0]              rd_q;
  logic [N_PORTS-1:0][BANK_W-1:0]  bank_q;
  logic [N_PORTS-1:0][tcdm_pkg::SRC_W-1:0] src_q;

  // Granted reads only.
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      rd_d[p] = req.req[p] && req.gnt[p] && (req.opc[p] == tcdm_pkg::OPC_READ);
    end
  end

  // Tag follows the input every cycle, granted or not.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_q  <= '0;
      src_q <= '0;
    end else begin
      rd_q  <= rd_d;
      src_q <= req.src;
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= bank_i;
  end

  // Bank output is already registered, so it lines up with rd_q.
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      rdata_o[p] = '0;
      if (rd_q[p]) begin
        rdata_o[p] = bank.rdata[bank_q[p]];
      end
    end
  end

  assign valid_o = rd_q;
  assign src_o   = src_q;

endmodule

/* tcdm_top.sv */
// Multi-bank shared word memory top level with plain per-port request ports.
`timescale 1ns/1ps

module tcdm_top #(
  parameter int N_PORTS           = 4,
  parameter int N_BANKS           = 4,
  parameter int BANK_WORDS        = 16,
  parameter int WORD_INTERLEAVING = 1
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [N_PORTS-1:0]                       req_i,
  input  logic [N_PORTS-1:0][tcdm_pkg::ADDR_W-1:0] add_i,
  input  logic [N_PORTS-1:0][tcdm_pkg::BE_W-1:0]   be_i,
  input  logic [N_PORTS-1:0][tcdm_pkg::DATA_W-1:0] wdata_i,
  input  logic [N_PORTS-1:0]                       opc_i,
  input  logic [N_PORTS-1:0][tcdm_pkg::SRC_W-1:0]  src_i,
  output logic [N_PORTS-1:0]                       gnt_o,
  output logic [N_PORTS-1:0]                       valid_o,
  output logic [N_PORTS-1:0][tcdm_pkg::DATA_W-1:0] rdata_o,
  output logic [N_PORTS-1:0][tcdm_pkg::SRC_W-1:0]  src_o
);

  localparam int BANK_W = $clog2(N_BANKS);
  localparam int ROW_W  = $clog2(BANK_WORDS);

  logic [N_PORTS-1:0][BANK_W-1:0] bank_sel;
  logic [N_PORTS-1:0][ROW_W-1:0]  row_sel;

  tcdm_req_if #(.N_PORTS(N_PORTS)) req_if ();

  tcdm_bank_if #(
    .N_BANKS   (N_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) bank_if ();

  // Plain ports onto the request bundle.
  assign req_if.req   = req_i;
  assign req_if.add   = add_i;
  assign req_if.be    = be_i;
  assign req_if.wdata = wdata_i;
  assign req_if.opc   = opc_i;
  assign req_if.src   = src_i;
  assign gnt_o        = req_if.gnt;

  tcdm_bank_select #(
    .N_PORTS          (N_PORTS),
    .N_BANKS          (N_BANKS),
    .BANK_WORDS       (BANK_WORDS),
    .WORD_INTERLEAVING(WORD_INTERLEAVING)
  ) u_bank_select (
    .req   (req_if.mon),
    .bank_o(bank_sel),
    .row_o (row_sel)
  );

  tcdm_arbiter #(
    .N_PORTS   (N_PORTS),
    .N_BANKS   (N_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) u_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_if.arb),
    .bank_i(bank_sel),
    .row_i (row_sel),
    .bank  (bank_if.ctrl)
  );

  for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
    tcdm_bank #(
      .BANK_WORDS(BANK_WORDS),
      .BANK_IDX  (g)
    ) u_bank (
      .clk  (clk),
      .rst_n(rst_n),
      .bank (bank_if.mem)
    );
  end

  tcdm_resp_route #(
    .N_PORTS(N_PORTS),
    .N_BANKS(N_BANKS)
  ) u_resp_route (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req_if.mon),
    .bank_i (bank_sel),
    .bank   (bank_if.rd),
    .rdata_o(rdata_o),
    .valid_o(valid_o),
    .src_o  (src_o)
  );

endmodule
